// File: src.f
rtl/bridge_pkg.sv
rtl/axi_cmd_front.sv
rtl/cmd_buffer.sv
rtl/ahb_xfer_fsm.sv
rtl/axi2ahb_bridge.sv
dv/tb_clock_gen.sv
dv/tb_axi2ahb_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_axi2ahb_bridge -f src.f \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_axi2ahb_bridge > sim.log 2>&1 || true
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: dv/tb_axi2ahb_bridge.sv
// Testbench for the AXI to AHB-Lite bridge
// Directed AXI tests against an AHB slave memory with random wait
// states and an error window

`timescale 1ns/10ps

module tb_axi2ahb_bridge import bridge_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 500;
  localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_f000;

  logic              buf_clk;
  logic              rst_l;
  logic              aw_valid;
  logic              aw_ready;
  logic [ID_W-1:0]   aw_id;
  logic [ADDR_W-1:0] aw_addr;
  logic [2:0]        aw_size;
  logic              w_valid;
  logic              w_ready;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              b_valid;
  logic              b_ready;
  logic [ID_W-1:0]   b_id;
  logic [1:0]        b_resp;
  logic              ar_valid;
  logic              ar_ready;
  logic [ID_W-1:0]   ar_id;
  logic [ADDR_W-1:0] ar_addr;
  logic [2:0]        ar_size;
  logic              r_valid;
  logic              r_ready;
  logic [ID_W-1:0]   r_id;
  logic [DATA_W-1:0] r_data;
  logic [1:0]        r_resp;
  logic              r_last;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [1:0]        htrans;
  logic [2:0]        hburst;
  logic [3:0]        hprot;
  logic              hmastlock;
  logic              hreadyin;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] hrdata    = '0;
  logic              hreadyout = 1'b1;
  logic              hresp     = 1'b0;

  // Slave memory and the log of accepted address phases
  logic [7:0]        mem [0:255];
  logic [ADDR_W-1:0] xfer_addr_q[$];
  logic [2:0]        xfer_size_q[$];
  logic              xfer_write_q[$];
  integer            seed = 32'h4c32c0ed;
  logic              dp_active = 1'b0;
  logic              dp_write;
  logic              dp_err;
  logic [ADDR_W-1:0] dp_addr;
  logic [2:0]        dp_size;
  int                wait_left;
  int                err_step;
  string             test_name;

  tb_clock_gen clock_gen_i (.buf_clk, .rst_l);

  axi2ahb_bridge axi2ahb_bridge_i (.*);

  //////////////////////////////////////////////////
  // AHB slave model
  //////////////////////////////////////////////////

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 13 + 7);
  endfunction

  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] word;
    for (int i = 0; i < STRB_W; i++) begin
      word[8*i +: 8] = mem[{a[7:3], 3'(i)}];
    end
    return word;
  endfunction

  task automatic store_bytes(input logic [ADDR_W-1:0] a, input logic [2:0] size,
                             input logic [DATA_W-1:0] data);
    int lane;
    for (int i = 0; i < (1 << size); i++) begin
      lane = int'(a[2:0]) + i;
      mem[{a[7:3], 3'(lane)}] = data[8*lane +: 8];
    end
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_byte(i);
    end
  end

  always @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      hreadyout <= 1'b1;
      hresp     <= 1'b0;
      dp_active = 1'b0;
    end else begin
      // Data phase ends on a ready edge
      if (dp_active && hreadyout) begin
        if (dp_write && !dp_err) store_bytes(dp_addr, dp_size, hwdata);
        dp_active = 1'b0;
      end
      if (htrans == HTRANS_NONSEQ && hreadyout) begin
        xfer_addr_q.push_back(haddr);
        xfer_size_q.push_back(hsize);
        xfer_write_q.push_back(hwrite);
        dp_active = 1'b1;
        dp_addr   = haddr;
        dp_size   = hsize;
        dp_write  = hwrite;
        dp_err    = (haddr >= ERR_BASE) && (haddr < ERR_BASE + 32'h100);
        wait_left = $random(seed) & 3;
        err_step  = 0;
      end
      // Two-cycle error response
      if (dp_active && dp_err) begin
        hresp     <= 1'b1;
        hreadyout <= (err_step == 1);
        err_step  = err_step + 1;
      end else if (dp_active && wait_left > 0) begin
        hresp     <= 1'b0;
        hreadyout <= 1'b0;
        wait_left = wait_left - 1;
      end else begin
        hresp     <= 1'b0;
        hreadyout <= dp_active || (($random(seed) & 3) != 0);
        hrdata    <= read_word(dp_addr);
      end
    end
  end

  //////////////////////////////////////////////////
  // Checking and AXI drivers
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic xfer_clear();
    xfer_addr_q.delete();
    xfer_size_q.delete();
    xfer_write_q.delete();
  endtask

  task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    aw_valid <= 1'b1;
    aw_id    <= id;
    aw_addr  <= addr;
    aw_size  <= 3'd3;
    @(posedge buf_clk);
    while (!aw_ready) @(posedge buf_clk);
    aw_valid <= 1'b0;
  endtask

  task automatic send_w(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    w_valid <= 1'b1;
    w_data  <= data;
    w_strb  <= strb;
    @(posedge buf_clk);
    while (!w_ready) @(posedge buf_clk);
    w_valid <= 1'b0;
  endtask

  task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    ar_valid <= 1'b1;
    ar_id    <= id;
    ar_addr  <= addr;
    ar_size  <= 3'd3;
    @(posedge buf_clk);
    while (!ar_ready) @(posedge buf_clk);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_b(output logic [ID_W-1:0] id, output logic [1:0] resp);
    @(posedge buf_clk);
    while (!b_valid) @(posedge buf_clk);
    id   = b_id;
    resp = b_resp;
  endtask

  task automatic wait_r(output logic [ID_W-1:0] id, output logic [DATA_W-1:0] data,
                        output logic [1:0] resp, output logic last);
    @(posedge buf_clk);
    while (!r_valid) @(posedge buf_clk);
    id   = r_id;
    data = r_data;
    resp = r_resp;
    last = r_last;
  endtask

  task automatic do_write(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                          input logic w_first, output logic [ID_W-1:0] bid,
                          output logic [1:0] bresp);
    if (w_first) begin
      send_w(data, strb);
      send_aw(id, addr);
    end else begin
      send_aw(id, addr);
      send_w(data, strb);
    end
    wait_b(bid, bresp);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    check_value("htrans", HTRANS_IDLE, htrans);
    check_value("b_valid", 1'b0, b_valid);
    check_value("r_valid", 1'b0, r_valid);
    check_value("aw_ready", 1'b1, aw_ready);
    check_value("w_ready", 1'b1, w_ready);
    check_value("ar_ready", 1'b0, ar_ready);
    // Fixed AHB sideband
    check_value("hsel", 1'b1, hsel);
    check_value("hreadyin", 1'b1, hreadyin);
    check_value("hburst", 3'b000, hburst);
    check_value("hprot", HPROT_DATA, hprot);
    check_value("hmastlock", 1'b0, hmastlock);
  endtask

  task automatic test_aligned_write();
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
    test_name = "aligned_write";
    xfer_clear();
    do_write(4'h1, 32'h1000, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, id, resp);
    check_value("xfers", 1, xfer_addr_q.size());
    check_value("haddr", 32'h1000, xfer_addr_q[0]);
    check_value("hsize", 3'd3, xfer_size_q[0]);
    check_value("b_id", 4'h1, id);
    check_value("b_resp", RESP_OKAY, resp);
    // Strobe 0x0c is a halfword at byte 2
    xfer_clear();
    do_write(4'h2, 32'h1008, 64'h1122_3344_5566_7788, 8'h0c, 1'b0, id, resp);
    check_value("xfers", 1, xfer_addr_q.size());
    check_value("haddr", 32'h100a, xfer_addr_q[0]);
    check_value("hsize", 3'd1, xfer_size_q[0]);
    check_value("mem byte 2", 8'h66, mem[8'h0a]);
    check_value("mem byte 3", 8'h55, mem[8'h0b]);
    check_value("b_id", 4'h2, id);
    check_value("b_resp", RESP_OKAY, resp);
  endtask

  task automatic test_unaligned_write();
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [ADDR_W-1:0] base;
    logic [DATA_W-1:0] data;
    logic [7:0]        exp_byte;
    int                offs[3] = '{0, 2, 5};
    for (int k = 0; k < 2; k++) begin
      test_name = (k == 1) ? "unaligned_write_w_first" : "unaligned_write";
      base = 32'h1040 + 32'(k) * 32'h40;
      data = 64'h8877_6655_4433_2211 + 64'(k);
      xfer_clear();
      do_write(4'h4, base, data, 8'h25, k == 1, id, resp);
      check_value("xfers", 3, xfer_addr_q.size());
      for (int i = 0; i < 3; i++) begin
        check_value("haddr", base + 32'(offs[i]), xfer_addr_q[i]);
        check_value("hsize", HSIZE_BYTE, xfer_size_q[i]);
        check_value("hwrite", 1'b1, xfer_write_q[i]);
      end
      for (int i = 0; i < STRB_W; i++) begin
        exp_byte = (i == 0 || i == 2 || i == 5) ? data[8*i +: 8]
                                                : fill_byte(int'(base[7:0]) + i);
        check_value("mem byte", exp_byte, mem[base[7:0] + 8'(i)]);
      end
      check_value("b_id", 4'h4, id);
      check_value("b_resp", RESP_OKAY, resp);
    end
  endtask

  task automatic test_read_after_write();
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
    logic              last;
    test_name = "read_after_write";
    do_write(4'h3, 32'h1010, 64'hdead_beef_0bad_f00d, 8'hff, 1'b0, id, resp);
    send_ar(4'h3, 32'h1010);
    wait_r(id, data, resp, last);
    check_value("r_data", 64'hdead_beef_0bad_f00d, data);
    check_value("r_resp", RESP_OKAY, resp);
    check_value("r_last", 1'b1, last);
    check_value("r_id", 4'h3, id);
    // Park a write in DONE so the next write and a read queue up together
    test_name = "write_before_read";
    b_ready <= 1'b0;
    send_aw(4'h5, 32'h1020);
    send_w(64'h5555_aaaa_5555_aaaa, 8'hff);
    wait_b(id, resp);
    send_aw(4'h6, 32'h10c0);
    send_w(64'h0f1e_2d3c_4b5a_6978, 8'hff);
    xfer_clear();
    fork
      send_ar(4'h7, 32'h10c0);
      begin
        b_ready <= 1'b1;
        wait_b(id, resp);
        wait_b(id, resp);
      end
    join
    check_value("b_id", 4'h6, id);
    wait_r(id, data, resp, last);
    check_value("xfers", 2, xfer_addr_q.size());
    check_value("first hwrite", 1'b1, xfer_write_q[0]);
    check_value("second hwrite", 1'b0, xfer_write_q[1]);
    check_value("second haddr", 32'h10c0, xfer_addr_q[1]);
    check_value("r_data", 64'h0f1e_2d3c_4b5a_6978, data);
    check_value("r_id", 4'h7, id);
  endtask

  task automatic test_error();
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
    logic              last;
    logic [ADDR_W-1:0] rd_addr;
    test_name = "error";
    rd_addr = ERR_BASE + 32'h8;
    do_write(4'h8, ERR_BASE, 64'h1234_5678_9abc_def0, 8'hff, 1'b0, id, resp);
    check_value("b_resp", RESP_SLVERR, resp);
    check_value("b_id", 4'h8, id);
    send_ar(4'h9, rd_addr);
    wait_r(id, data, resp, last);
    check_value("r_resp", RESP_SLVERR, resp);
    check_value("r_data", {2{rd_addr}}, data);
    check_value("r_id", 4'h9, id);
    check_value("r_last", 1'b1, last);
  endtask

  task automatic test_backpressure();
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] held;
    logic              last;
    test_name = "backpressure";
    r_ready <= 1'b0;
    send_ar(4'ha, 32'h1010);
    wait_r(id, data, resp, last);
    held = data;
    xfer_clear();
    send_aw(4'hb, 32'h1030);
    send_w(64'h7777_8888_9999_0000, 8'hff);
    repeat (8) begin
      @(posedge buf_clk);
      check_value("r_valid", 1'b1, r_valid);
      check_value("r_data", held, r_data);
      check_value("xfers", 0, xfer_addr_q.size());
    end
    r_ready <= 1'b1;
    wait_r(id, data, resp, last);
    check_value("r_data", 64'hdead_beef_0bad_f00d, data);
    check_value("r_id", 4'ha, id);
    wait_b(id, resp);
    check_value("b_id", 4'hb, id);
    check_value("xfers", 1, xfer_addr_q.size());
  endtask

  // Watchdog
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAILED");
    $fatal(1, "simulation timeout");
  end

  initial begin
    aw_valid <= 1'b0;
    aw_id    <= '0;
    aw_addr  <= '0;
    aw_size  <= '0;
    w_valid  <= 1'b0;
    w_data   <= '0;
    w_strb   <= '0;
    ar_valid <= 1'b0;
    ar_id    <= '0;
    ar_addr  <= '0;
    ar_size  <= '0;
    b_ready  <= 1'b1;
    r_ready  <= 1'b1;
    wait (rst_l === 1'b1);
    @(posedge buf_clk);
    test_reset();
    test_aligned_write();
    test_unaligned_write();
    test_read_after_write();
    test_error();
    test_backpressure();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns clock, reset held low for the first three rising edges

`timescale 1ns/10ps

module tb_clock_gen (
  output logic buf_clk,
  output logic rst_l
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 3;

  initial begin
    buf_clk = 1'b0;
    forever #HALF_PERIOD buf_clk = ~buf_clk;
  end

  initial begin
    rst_l = 1'b0;
    repeat (RST_CYCLES) @(posedge buf_clk);
    rst_l <= 1'b1;
  end

endmodule

// File: rtl/axi2ahb_bridge.sv
// AXI to AHB-Lite bridge top level
// Single-beat AXI writes and reads become AHB-Lite transfers

`timescale 1ns/10ps

module axi2ahb_bridge import bridge_pkg::*; (
  input  logic              buf_clk,
  input  logic              rst_l,
  // AXI write address
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [ID_W-1:0]   aw_id,
  input  logic [ADDR_W-1:0] aw_addr,
  input  logic [2:0]        aw_size,
  // AXI write data
  input  logic              w_valid,
  output logic              w_ready,
  input  logic [DATA_W-1:0] w_data,
  input  logic [STRB_W-1:0] w_strb,
  // AXI write response
  output logic              b_valid,
  input  logic              b_ready,
  output logic [ID_W-1:0]   b_id,
  output logic [1:0]        b_resp,
  // AXI read address
  input  logic              ar_valid,
  output logic              ar_ready,
  input  logic [ID_W-1:0]   ar_id,
  input  logic [ADDR_W-1:0] ar_addr,
  input  logic [2:0]        ar_size,
  // AXI read data
  output logic              r_valid,
  input  logic              r_ready,
  output logic [ID_W-1:0]   r_id,
  output logic [DATA_W-1:0] r_data,
  output logic [1:0]        r_resp,
  output logic              r_last,
  // AHB-Lite master
  output logic              hsel,
  output logic [ADDR_W-1:0] haddr,
  output logic              hwrite,
  output logic [2:0]        hsize,
  output logic [1:0]        htrans,
  output logic [2:0]        hburst,
  output logic [3:0]        hprot,
  output logic              hmastlock,
  output logic              hreadyin,
  output logic [DATA_W-1:0] hwdata,
  input  logic [DATA_W-1:0] hrdata,
  input  logic              hreadyout,
  input  logic              hresp
);

  logic              cmd_valid;
  logic              cmd_ready;
  logic              cmd_write;
  logic [ID_W-1:0]   cmd_tag;
  logic [ADDR_W-1:0] cmd_addr;
  logic [2:0]        cmd_size;
  logic [DATA_W-1:0] cmd_wdata;
  logic [STRB_W-1:0] cmd_strb;

  logic              ent_valid;
  logic              ent_write;
  logic [ID_W-1:0]   ent_tag;
  logic [ADDR_W-1:0] ent_addr;
  logic [1:0]        ent_size;
  logic              ent_aligned;
  logic [STRB_W-1:0] ent_strb;
  logic [DATA_W-1:0] ent_wdata;
  logic              ent_done;

  // Fixed AHB sideband, single transfers only
  assign hsel      = 1'b1;
  assign hreadyin  = 1'b1;
  assign hburst    = 3'b000;
  assign hprot     = HPROT_DATA;
  assign hmastlock = 1'b0;
  assign r_last    = 1'b1;

  axi_cmd_front axi_cmd_front_i (
    .buf_clk, .rst_l,
    .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_size,
    .w_valid, .w_ready, .w_data, .w_strb,
    .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_size,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_tag, .cmd_addr, .cmd_size,
    .cmd_wdata, .cmd_strb
  );

  cmd_buffer cmd_buffer_i (
    .buf_clk, .rst_l,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_tag, .cmd_addr, .cmd_size,
    .cmd_wdata, .cmd_strb,
    .ent_valid, .ent_write, .ent_tag, .ent_addr, .ent_size, .ent_aligned,
    .ent_strb, .ent_wdata, .ent_done
  );

  ahb_xfer_fsm ahb_xfer_fsm_i (
    .buf_clk, .rst_l,
    .ent_valid, .ent_write, .ent_tag, .ent_addr, .ent_size, .ent_aligned,
    .ent_strb, .ent_wdata, .ent_done,
    .haddr, .hwrite, .hsize, .htrans, .hwdata, .hrdata, .hreadyout, .hresp,
    .b_valid, .b_ready, .b_id, .b_resp,
    .r_valid, .r_ready, .r_id, .r_data, .r_resp
  );

endmodule

// File: rtl/ahb_xfer_fsm.sv
// AHB-Lite master state machine
// Runs one buffered command on the bus, walking the strobe byte by
// byte for unaligned writes, and returns the AXI B or R response

`timescale 1ns/10ps

module ahb_xfer_fsm import bridge_pkg::*; (
  input  logic              buf_clk,
  input  logic              rst_l,
  // Buffer entry
  input  logic              ent_valid,
  input  logic              ent_write,
  input  logic [ID_W-1:0]   ent_tag,
  input  logic [ADDR_W-1:0] ent_addr,
  input  logic [1:0]        ent_size,
  input  logic              ent_aligned,
  input  logic [STRB_W-1:0] ent_strb,
  input  logic [DATA_W-1:0] ent_wdata,
  output logic              ent_done,
  // AHB master
  output logic [ADDR_W-1:0] haddr,
  output logic              hwrite,
  output logic [2:0]        hsize,
  output logic [1:0]        htrans,
  output logic [DATA_W-1:0] hwdata,
  input  logic [DATA_W-1:0] hrdata,
  input  logic              hreadyout,
  input  logic              hresp,
  // AXI responses
  output logic              b_valid,
  input  logic              b_ready,
  output logic [ID_W-1:0]   b_id,
  output logic [1:0]        b_resp,
  output logic              r_valid,
  input  logic              r_ready,
  output logic [ID_W-1:0]   r_id,
  output logic [DATA_W-1:0] r_data,
  output logic [1:0]        r_resp
);

  xfer_state_t       state_q;
  xfer_state_t       state_d;

  logic              hready_q;
  logic              hresp_q;
  logic [1:0]        htrans_q;
  logic [DATA_W-1:0] hrdata_q;
  logic [DATA_W-1:0] rdata_q;
  logic [ADDR_W-1:0] last_addr_q;
  logic [PTR_W-1:0]  byte_ptr_q;
  logic [PTR_W-1:0]  nxt_ptr;
  logic              err_q;

  logic              addr_done;
  logic              data_done;
  logic              in_data;
  logic              start;
  logic              more_bytes;

  //////////////////////////////////////////////////
  // Bus status and byte walk
  //////////////////////////////////////////////////

  // Address accepted on the previous edge
  assign addr_done = hready_q & (htrans_q == HTRANS_NONSEQ);
  // First error cycle ends the data phase as well
  assign data_done = hready_q | hresp_q;
  assign in_data   = (state_q == DATA_RD) | (state_q == DATA_WR);
  assign start     = (state_q == IDLE) & ent_valid;

  assign nxt_ptr    = next_byte_ptr(byte_ptr_q + PTR_W'(1), ent_strb);
  assign more_bytes = ~ent_aligned & (byte_ptr_q != '1) & ent_strb[nxt_ptr];

  //////////////////////////////////////////////////
  // Next state and transfer request
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    htrans  = HTRANS_IDLE;
    case (state_q)
      IDLE: begin
        if (ent_valid) state_d = ent_write ? CMD_WR : CMD_RD;
      end
      CMD_RD: begin
        if (addr_done) state_d = DATA_RD;
        else htrans = HTRANS_NONSEQ;
      end
      DATA_RD: begin
        if (data_done) state_d = DONE;
      end
      CMD_WR: begin
        if (addr_done) state_d = DATA_WR;
        else htrans = HTRANS_NONSEQ;
      end
      DATA_WR: begin
        // Next byte only after a clean data phase
        if (data_done) state_d = (hresp_q | ~more_bytes) ? DONE : CMD_WR;
      end
      DONE: begin
        if (ent_done) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      state_q    <= IDLE;
      hready_q   <= 1'b0;
      hresp_q    <= 1'b0;
      htrans_q   <= HTRANS_IDLE;
      byte_ptr_q <= '0;
      err_q      <= 1'b0;
    end else begin
      state_q  <= state_d;
      hready_q <= hreadyout;
      hresp_q  <= hresp;
      htrans_q <= htrans;
      if (start) begin
        byte_ptr_q <= next_byte_ptr('0, ent_strb);
        err_q      <= 1'b0;
      end else begin
        if (state_q == DATA_WR && data_done && more_bytes) byte_ptr_q <= nxt_ptr;
        if (in_data && data_done) err_q <= hresp_q;
      end
    end
  end

  // Read data and last bus address
  always_ff @(posedge buf_clk) begin
    hrdata_q <= hrdata;
    if (state_q == DATA_RD && data_done) rdata_q <= hrdata_q;
    if (addr_done) last_addr_q <= haddr;
  end

  //////////////////////////////////////////////////
  // AHB and AXI outputs
  //////////////////////////////////////////////////

  assign haddr  = ent_aligned ? ent_addr : {ent_addr[ADDR_W-1:PTR_W], byte_ptr_q};
  assign hsize  = ent_aligned ? {1'b0, ent_size} : HSIZE_BYTE;
  assign hwrite = ent_write;
  assign hwdata = ent_wdata;

  assign b_valid  = (state_q == DONE) & ent_write;
  assign r_valid  = (state_q == DONE) & ~ent_write;
  assign ent_done = (b_valid & b_ready) | (r_valid & r_ready);

  assign b_id   = ent_tag;
  assign r_id   = ent_tag;
  assign b_resp = err_q ? RESP_SLVERR : RESP_OKAY;
  assign r_resp = err_q ? RESP_SLVERR : RESP_OKAY;
  // Failing address doubled up on a read error
  assign r_data = err_q ? {2{last_addr_q}} : rdata_q;

endmodule

// File: rtl/cmd_buffer.sv
// One-entry command buffer
// Classifies write strobes as aligned or unaligned and folds an
// aligned strobe into the entry's address and size

`timescale 1ns/10ps

module cmd_buffer import bridge_pkg::*; (
  input  logic              buf_clk,
  input  logic              rst_l,
  // From the front end
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic              cmd_write,
  input  logic [ID_W-1:0]   cmd_tag,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [2:0]        cmd_size,
  input  logic [DATA_W-1:0] cmd_wdata,
  input  logic [STRB_W-1:0] cmd_strb,
  // To the AHB state machine
  output logic              ent_valid,
  output logic              ent_write,
  output logic [ID_W-1:0]   ent_tag,
  output logic [ADDR_W-1:0] ent_addr,
  output logic [1:0]        ent_size,
  output logic              ent_aligned,
  output logic [STRB_W-1:0] ent_strb,
  output logic [DATA_W-1:0] ent_wdata,
  input  logic              ent_done
);

  logic             cmd_move;
  logic             full_wr;
  logic             aligned_in;
  logic             use_strb;
  logic [PTR_W-1:0] addr_lo_in;
  logic [1:0]       size_in;

  assign cmd_ready = ~ent_valid;
  assign cmd_move  = cmd_valid & cmd_ready;

  // Only doubleword writes carry a strobe worth decoding
  assign full_wr    = cmd_write & (cmd_size == 3'd3);
  assign aligned_in = ~full_wr | strb_is_aligned(cmd_strb);
  assign use_strb   = full_wr & aligned_in;

  assign addr_lo_in = use_strb ? strb_offset(cmd_strb) : cmd_addr[PTR_W-1:0];
  assign size_in    = use_strb ? strb_size(cmd_strb) : cmd_size[1:0];

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      ent_valid <= 1'b0;
    end else if (cmd_move) begin
      ent_valid <= 1'b1;
    end else if (ent_done) begin
      ent_valid <= 1'b0;
    end
  end

  always_ff @(posedge buf_clk) begin
    if (cmd_move) begin
      ent_write   <= cmd_write;
      ent_tag     <= cmd_tag;
      ent_addr    <= {cmd_addr[ADDR_W-1:PTR_W], addr_lo_in};
      ent_size    <= size_in;
      ent_aligned <= aligned_in;
      ent_strb    <= cmd_strb;
      ent_wdata   <= cmd_wdata;
    end
  end

endmodule

// File: rtl/axi_cmd_front.sv
// AXI command front end
// Holds one write address and one write data in any arrival order,
// then picks the next command, a complete write before a read

`timescale 1ns/10ps

module axi_cmd_front import bridge_pkg::*; (
  input  logic              buf_clk,
  input  logic              rst_l,
  // AXI write address
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [ID_W-1:0]   aw_id,
  input  logic [ADDR_W-1:0] aw_addr,
  input  logic [2:0]        aw_size,
  // AXI write data
  input  logic              w_valid,
  output logic              w_ready,
  input  logic [DATA_W-1:0] w_data,
  input  logic [STRB_W-1:0] w_strb,
  // AXI read address
  input  logic              ar_valid,
  output logic              ar_ready,
  input  logic [ID_W-1:0]   ar_id,
  input  logic [ADDR_W-1:0] ar_addr,
  input  logic [2:0]        ar_size,
  // Command to the buffer
  output logic              cmd_valid,
  input  logic              cmd_ready,
  output logic              cmd_write,
  output logic [ID_W-1:0]   cmd_tag,
  output logic [ADDR_W-1:0] cmd_addr,
  output logic [2:0]        cmd_size,
  output logic [DATA_W-1:0] cmd_wdata,
  output logic [STRB_W-1:0] cmd_strb
);

  logic              aw_held;
  logic              w_held;
  logic [ID_W-1:0]   aw_tag_q;
  logic [ADDR_W-1:0] aw_addr_q;
  logic [2:0]        aw_size_q;
  logic [DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0] w_strb_q;

  logic aw_fire;
  logic w_fire;
  logic wr_full;
  logic wr_move;

  //////////////////////////////////////////////////
  // Write holding stage
  //////////////////////////////////////////////////

  assign aw_ready = ~aw_held;
  assign w_ready  = ~w_held;
  assign aw_fire  = aw_valid & aw_ready;
  assign w_fire   = w_valid & w_ready;
  assign wr_full  = aw_held & w_held;
  assign wr_move  = wr_full & cmd_ready;

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      // A held half cannot be refilled, so fire and move never overlap
      if (aw_fire) aw_held <= 1'b1;
      else if (wr_move) aw_held <= 1'b0;
      if (w_fire) w_held <= 1'b1;
      else if (wr_move) w_held <= 1'b0;
    end
  end

  always_ff @(posedge buf_clk) begin
    if (aw_fire) begin
      aw_tag_q  <= aw_id;
      aw_addr_q <= aw_addr;
      aw_size_q <= aw_size;
    end
    if (w_fire) begin
      w_data_q <= w_data;
      w_strb_q <= w_strb;
    end
  end

  //////////////////////////////////////////////////
  // Command select
  //////////////////////////////////////////////////

  assign cmd_valid = wr_full | ar_valid;
  assign cmd_write = wr_full;
  assign cmd_tag   = wr_full ? aw_tag_q  : ar_id;
  assign cmd_addr  = wr_full ? aw_addr_q : ar_addr;
  assign cmd_size  = wr_full ? aw_size_q : ar_size;
  assign cmd_wdata = w_data_q;
  assign cmd_strb  = w_strb_q;

  // Read is taken only when no complete write is waiting
  assign ar_ready = ar_valid & ~wr_full & cmd_ready;

endmodule

// File: rtl/bridge_pkg.sv
// Shared definitions for the AXI to AHB-Lite bridge
// Bus widths, AHB and AXI codes, FSM states and strobe decoding

package bridge_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;
  localparam int ID_W   = 4;
  localparam int PTR_W  = 3;

  // AHB transfer and size codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [2:0] HSIZE_BYTE    = 3'b000;
  localparam logic [3:0] HPROT_DATA    = 4'b0011;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    CMD_RD  = 3'd1,
    DATA_RD = 3'd2,
    CMD_WR  = 3'd3,
    DATA_WR = 3'd4,
    DONE    = 3'd5
  } xfer_state_t;

  // Transfer size for a naturally aligned strobe pattern
  function automatic logic [1:0] strb_size(input logic [STRB_W-1:0] strb);
    logic [1:0] size;
    case (strb)
      8'hff:                      size = 2'd3;
      8'h0f, 8'hf0:               size = 2'd2;
      8'h03, 8'h0c, 8'h30, 8'hc0: size = 2'd1;
      default:                    size = 2'd0;
    endcase
    return size;
  endfunction

  // Byte offset of the first enabled lane
  function automatic logic [PTR_W-1:0] strb_offset(input logic [STRB_W-1:0] strb);
    logic [PTR_W-1:0] offset;
    case (strb)
      8'h0c:        offset = 3'd2;
      8'hf0, 8'h30: offset = 3'd4;
      8'hc0:        offset = 3'd6;
      default:      offset = 3'd0;
    endcase
    return offset;
  endfunction

  function automatic logic strb_is_aligned(input logic [STRB_W-1:0] strb);
    logic aligned;
    case (strb)
      8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0: aligned = 1'b1;
      default:                                         aligned = 1'b0;
    endcase
    return aligned;
  endfunction

  // First set strobe bit at or after start, 7 when none is left
  function automatic logic [PTR_W-1:0] next_byte_ptr(input logic [PTR_W-1:0] start,
                                                     input logic [STRB_W-1:0] strb);
    logic             found;
    logic [PTR_W-1:0] ptr;
    found = 1'b0;
    ptr   = '1;
    for (int j = 0; j < STRB_W; j++) begin
      if (!found && strb[j] && (j >= int'(start))) begin
        ptr   = PTR_W'(j);
        found = 1'b1;
      end
    end
    return ptr;
  endfunction

endpackage
